/* verilog/cmd_xfer_pkg.sv */
package cmd_xfer_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    // Accumulator and result width
    localparam int ACC_W = 16;

    // Command argument width, packs with the opcode into 16 bits
    localparam int ARG_W = 14;

    // ------------------------------------------------------------------
    // Command format
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_LOAD = 2'd2,
        OP_OUT  = 2'd3
    } cmd_op_t;

    typedef struct packed {
        cmd_op_t          op;
        logic [ARG_W-1:0] arg;
    } cmd_t;

    // FIFO count width
    // FWFT adds the output register, so up to DEPTH+1 entries are held
    function automatic int fifo_cnt_w(input int depth, input bit fwft);
        return fwft ? $clog2(depth + 2) : $clog2(depth + 1);
    endfunction

endpackage : cmd_xfer_pkg

/* verilog/fifo_port_if.sv */
`timescale 1ns/100ps

// Write port of the FIFO, wr_clk domain
interface fifo_wr_if #(
    parameter int CNT_W = cmd_xfer_pkg::fifo_cnt_w(16, 1'b1)
);
    import cmd_xfer_pkg::*;

    logic             wr;
    cmd_t             wr_data;
    logic             full;
    logic             oflow;
    logic [CNT_W-1:0] wr_count;

    modport producer (
        output wr,
        output wr_data,
        input  full,
        input  oflow,
        input  wr_count
    );

    modport fifo (
        input  wr,
        input  wr_data,
        output full,
        output oflow,
        output wr_count
    );

endinterface : fifo_wr_if

// Read port of the FIFO, rd_clk domain
interface fifo_rd_if #(
    parameter int CNT_W = cmd_xfer_pkg::fifo_cnt_w(16, 1'b1)
);
    import cmd_xfer_pkg::*;

    logic             rd;
    logic             rd_ack;
    cmd_t             rd_data;
    logic             empty;
    logic             uflow;
    logic [CNT_W-1:0] rd_count;

    modport consumer (
        output rd,
        input  rd_ack,
        input  rd_data,
        input  empty,
        input  uflow,
        input  rd_count
    );

    modport fifo (
        input  rd,
        output rd_ack,
        output rd_data,
        output empty,
        output uflow,
        output rd_count
    );

endinterface : fifo_rd_if

/* verilog/fifo_core.sv */
`timescale 1ns/100ps

module fifo_core #(
    parameter int DEPTH      = 16,
    parameter bit ASYNC      = 1,
    parameter bit FWFT       = 1,
    parameter bit OFLOW_PROT = 1,
    parameter bit UFLOW_PROT = 1,
    localparam int CNT_W     = cmd_xfer_pkg::fifo_cnt_w(DEPTH, FWFT)
) (
    input  logic               wr_clk,
    input  logic               wr_srst,
    input  logic               wr,
    input  cmd_xfer_pkg::cmd_t wr_data,
    output logic               full,
    output logic               oflow,
    output logic [CNT_W-1:0]   wr_count,

    input  logic               rd_clk,
    input  logic               rd_srst,
    input  logic               rd,
    output logic               rd_ack,
    output cmd_xfer_pkg::cmd_t rd_data,
    output logic               empty,
    output logic               uflow,
    output logic [CNT_W-1:0]   rd_count
);
    import cmd_xfer_pkg::*;

    localparam int AW = $clog2(DEPTH);

    function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
        logic [AW:0] b;
        b[AW] = g[AW];
        for (int i = AW - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    cmd_t        mem [DEPTH];
    logic [AW:0] wr_ptr_bin, wr_ptr_gray, wr_ptr_nxt, rd_gray_sync;
    logic [AW:0] rd_ptr_bin, rd_ptr_gray, rd_ptr_nxt, wr_gray_sync;
    logic        wr_en, mem_empty, mem_rd, head_avail, rd_ok;
    logic        stage_full, rd_ack_q;

    // ------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------
    assign wr_en      = wr && (!full || !OFLOW_PROT);
    assign wr_ptr_nxt = wr_ptr_bin + 1'b1;
    // Full when the pointers differ only in the two top gray bits
    assign full     = (wr_ptr_gray == {~rd_gray_sync[AW:AW-1], rd_gray_sync[AW-2:0]});
    assign wr_count = CNT_W'(wr_ptr_bin - gray2bin(rd_gray_sync));

    always_ff @(posedge wr_clk) begin
        if (wr_srst) begin
            wr_ptr_bin  <= '0;
            wr_ptr_gray <= '0;
            oflow       <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr_bin  <= wr_ptr_nxt;
                wr_ptr_gray <= bin2gray(wr_ptr_nxt);
            end
            oflow <= OFLOW_PROT && wr && full;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_ptr_bin[AW-1:0]] <= wr_data;
        end
    end

    // ------------------------------------------------------------------
    // Pointer crossing
    // ------------------------------------------------------------------
    if (ASYNC) begin : g_async
        logic [AW:0] wr_gray_meta, rd_gray_meta;

        always_ff @(posedge rd_clk) begin
            if (rd_srst) begin
                wr_gray_meta <= '0;
                wr_gray_sync <= '0;
            end else begin
                wr_gray_meta <= wr_ptr_gray;
                wr_gray_sync <= wr_gray_meta;
            end
        end

        always_ff @(posedge wr_clk) begin
            if (wr_srst) begin
                rd_gray_meta <= '0;
                rd_gray_sync <= '0;
            end else begin
                rd_gray_meta <= rd_ptr_gray;
                rd_gray_sync <= rd_gray_meta;
            end
        end
    end else begin : g_sync
        // Single clock, pointers are used directly
        assign wr_gray_sync = wr_ptr_gray;
        assign rd_gray_sync = rd_ptr_gray;
    end

    // ------------------------------------------------------------------
    // Read side and FWFT output register
    // ------------------------------------------------------------------
    assign mem_empty  = (rd_ptr_gray == wr_gray_sync);
    assign head_avail = FWFT ? stage_full : !mem_empty;
    assign rd_ok      = rd && (head_avail || !UFLOW_PROT);
    // FWFT refills the output register whenever it is free or popped
    assign mem_rd     = FWFT ? (!mem_empty && (!stage_full || rd_ok)) : rd_ok;
    assign rd_ptr_nxt = rd_ptr_bin + 1'b1;
    assign empty      = !head_avail;
    assign rd_ack     = FWFT ? rd_ok : rd_ack_q;
    assign rd_count   = CNT_W'(gray2bin(wr_gray_sync) - rd_ptr_bin) +
                        ((FWFT && stage_full) ? CNT_W'(1) : CNT_W'(0));

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
            stage_full  <= 1'b0;
            rd_ack_q    <= 1'b0;
            uflow       <= 1'b0;
        end else begin
            if (mem_rd) begin
                rd_ptr_bin  <= rd_ptr_nxt;
                rd_ptr_gray <= bin2gray(rd_ptr_nxt);
            end
            stage_full <= FWFT && (mem_rd || (stage_full && !rd_ok));
            rd_ack_q   <= rd_ok;
            uflow      <= UFLOW_PROT && rd && !head_avail;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (mem_rd) begin
            rd_data <= mem[rd_ptr_bin[AW-1:0]];
        end
    end

endmodule : fifo_core

/* verilog/fifo_async.sv */
`timescale 1ns/100ps

module fifo_async #(
    parameter int DEPTH      = 16,
    parameter bit FWFT       = 1,
    parameter bit OFLOW_PROT = 1,
    parameter bit UFLOW_PROT = 1,
    localparam int CNT_W     = cmd_xfer_pkg::fifo_cnt_w(DEPTH, FWFT)
) (
    input  logic             wr_clk,
    input  logic             wr_srst,
    input  logic             rd_clk,
    input  logic             rd_srst,
    fifo_wr_if.fifo          wr_port,
    fifo_rd_if.fifo          rd_port,
    output logic [CNT_W-1:0] fifo_level
);

    logic [CNT_W-1:0] core_rd_count;
    logic [CNT_W-1:0] rd_count_q;

    fifo_core #(
        .DEPTH      (DEPTH),
        .ASYNC      (1'b1),
        .FWFT       (FWFT),
        .OFLOW_PROT (OFLOW_PROT),
        .UFLOW_PROT (UFLOW_PROT)
    ) fifo_core_inst (
        .wr_clk   (wr_clk),
        .wr_srst  (wr_srst),
        .wr       (wr_port.wr),
        .wr_data  (wr_port.wr_data),
        .full     (wr_port.full),
        .oflow    (wr_port.oflow),
        .wr_count (wr_port.wr_count),
        .rd_clk   (rd_clk),
        .rd_srst  (rd_srst),
        .rd       (rd_port.rd),
        .rd_ack   (rd_port.rd_ack),
        .rd_data  (rd_port.rd_data),
        .empty    (rd_port.empty),
        .uflow    (rd_port.uflow),
        .rd_count (core_rd_count)
    );

    // Read-side level, one rd_clk behind the core
    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            rd_count_q <= '0;
        end else begin
            rd_count_q <= core_rd_count;
        end
    end

    assign rd_port.rd_count = rd_count_q;
    assign fifo_level       = rd_count_q;

endmodule : fifo_async

/* verilog/cmd_producer.sv */
`timescale 1ns/100ps

module cmd_producer #(
    parameter int CNT_W = 5
) (
    input  logic                                wr_clk,
    input  logic                                wr_srst,
    input  logic                                cmd_valid,
    input  cmd_xfer_pkg::cmd_op_t               cmd_op,
    input  logic [cmd_xfer_pkg::ARG_W-1:0]      cmd_arg,
    output logic                                cmd_ready,
    output logic [15:0]                         cmd_count,
    fifo_wr_if.producer                         wr_port
);
    import cmd_xfer_pkg::*;

    logic hold_valid;
    cmd_t hold_cmd;
    logic ready_en;
    logic wr_fire;
    logic accept;

    // Count width of the port has to agree with the FIFO configuration
    if ($bits(wr_port.wr_count) != CNT_W) begin : g_width_chk
        $error("cmd_producer: CNT_W does not match the FIFO write port");
    end

    // full is built from wr_clk registers only, so this stays registered
    assign wr_fire   = hold_valid && !wr_port.full;
    assign cmd_ready = ready_en && (!hold_valid || wr_fire);
    assign accept    = cmd_valid && cmd_ready;

    assign wr_port.wr      = wr_fire;
    assign wr_port.wr_data = hold_cmd;

    always_ff @(posedge wr_clk) begin
        if (wr_srst) begin
            ready_en   <= 1'b0;
            hold_valid <= 1'b0;
            cmd_count  <= '0;
        end else begin
            // Input held off until the first cycle after reset
            ready_en <= 1'b1;
            if (accept) begin
                hold_valid <= 1'b1;
                cmd_count  <= cmd_count + 16'd1;
            end else if (wr_fire) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (accept) begin
            hold_cmd <= '{op: cmd_op, arg: cmd_arg};
        end
    end

endmodule : cmd_producer

/* verilog/cmd_consumer.sv */
`timescale 1ns/100ps

module cmd_consumer (
    input  logic                           rd_clk,
    input  logic                           rd_srst,
    fifo_rd_if.consumer                    rd_port,
    output logic                           res_valid,
    output logic [cmd_xfer_pkg::ACC_W-1:0] res_data,
    input  logic                           res_ready
);
    import cmd_xfer_pkg::*;

    typedef enum logic {
        IDLE_ST,
        HOLD_ST
    } state_t;

    state_t           state;
    cmd_t             head;
    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] arg_ext;
    logic             drain;
    logic             head_out;
    logic             pop;

    assign head     = rd_port.rd_data;
    assign arg_ext  = ACC_W'(head.arg);
    assign head_out = (head.op == OP_OUT);
    assign drain    = res_valid && res_ready;

    // ------------------------------------------------------------------
    // Pop control
    // ------------------------------------------------------------------
    // OUT waits for a free result register, other opcodes never stall
    assign rd_port.rd = !rd_port.empty && (!head_out || state == IDLE_ST || drain);
    assign pop        = rd_port.rd_ack;
    assign res_valid  = (state == HOLD_ST);

    // ------------------------------------------------------------------
    // Execution
    // ------------------------------------------------------------------
    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            state <= IDLE_ST;
            acc   <= '0;
        end else begin
            if (pop) begin
                case (head.op)
                    OP_ADD:  acc <= acc + arg_ext;
                    OP_SUB:  acc <= acc - arg_ext;
                    OP_LOAD: acc <= arg_ext;
                    default: acc <= acc;
                endcase
            end
            if (pop && head_out) begin
                state <= HOLD_ST;
            end else if (drain) begin
                state <= IDLE_ST;
            end
        end
    end

    // Result register, only loaded when empty or draining
    always_ff @(posedge rd_clk) begin
        if (pop && head_out) begin
            res_data <= acc;
        end
    end

endmodule : cmd_consumer

/* verilog/cmd_xfer_top.sv */
`timescale 1ns/100ps

module cmd_xfer_top #(
    parameter int DEPTH      = 16,
    parameter bit FWFT       = 1,
    parameter bit OFLOW_PROT = 1,
    parameter bit UFLOW_PROT = 1,
    localparam int CNT_W     = cmd_xfer_pkg::fifo_cnt_w(DEPTH, FWFT)
) (
    input  logic                           wr_clk,
    input  logic                           wr_srst,
    input  logic                           rd_clk,
    input  logic                           rd_srst,

    // Command input, wr_clk domain
    input  logic                           cmd_valid,
    input  cmd_xfer_pkg::cmd_op_t          cmd_op,
    input  logic [cmd_xfer_pkg::ARG_W-1:0] cmd_arg,
    output logic                           cmd_ready,
    output logic [15:0]                    cmd_count,

    // Results, rd_clk domain
    output logic                           res_valid,
    output logic [cmd_xfer_pkg::ACC_W-1:0] res_data,
    input  logic                           res_ready,
    output logic [CNT_W-1:0]               fifo_level
);

    fifo_wr_if #(.CNT_W(CNT_W)) wr_if ();
    fifo_rd_if #(.CNT_W(CNT_W)) rd_if ();

    cmd_producer #(
        .CNT_W (CNT_W)
    ) cmd_producer_inst (
        .wr_clk    (wr_clk),
        .wr_srst   (wr_srst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_arg   (cmd_arg),
        .cmd_ready (cmd_ready),
        .cmd_count (cmd_count),
        .wr_port   (wr_if.producer)
    );

    fifo_async #(
        .DEPTH      (DEPTH),
        .FWFT       (FWFT),
        .OFLOW_PROT (OFLOW_PROT),
        .UFLOW_PROT (UFLOW_PROT)
    ) fifo_async_inst (
        .wr_clk     (wr_clk),
        .wr_srst    (wr_srst),
        .rd_clk     (rd_clk),
        .rd_srst    (rd_srst),
        .wr_port    (wr_if.fifo),
        .rd_port    (rd_if.fifo),
        .fifo_level (fifo_level)
    );

    cmd_consumer cmd_consumer_inst (
        .rd_clk    (rd_clk),
        .rd_srst   (rd_srst),
        .rd_port   (rd_if.consumer),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_ready (res_ready)
    );

endmodule : cmd_xfer_top

/* tb/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen #(
    parameter real PERIOD_NS  = 10.0,
    parameter int  RST_CYCLES = 10
) (
    output logic clk,
    output logic srst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        srst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        srst <= 1'b0;
    end

endmodule : tb_clkgen

/* tb/cmd_xfer_assertions.sv */
`timescale 1ns/100ps

module cmd_xfer_assertions (
    input logic clk,
    input logic srst,
    input logic req,
    input logic blocked,
    input logic err_flag
);

    int fail_count = 0;

    // Request only when the FIFO side can take it
    a_req_blocked: assert property (@(posedge clk) disable iff (srst) !(req && blocked))
        else begin
            fail_count++;
            $error("FIFO request raised while the FIFO side was blocked");
        end

    // Protection flags stay quiet
    a_err_flag: assert property (@(posedge clk) disable iff (srst) !err_flag)
        else begin
            fail_count++;
            $error("FIFO overflow or underflow flag raised");
        end

    a_req_known: assert property (@(posedge clk) disable iff (srst) !$isunknown(req))
        else begin
            fail_count++;
            $error("FIFO request is unknown");
        end

endmodule : cmd_xfer_assertions

// ----------------------------------------------------------------------
// Write side at the FIFO, read side at the consumer
// ----------------------------------------------------------------------
bind fifo_async cmd_xfer_assertions wr_side_chk (
    .clk      (wr_clk),
    .srst     (wr_srst),
    .req      (wr_port.wr),
    .blocked  (wr_port.full),
    .err_flag (wr_port.oflow)
);

bind cmd_consumer cmd_xfer_assertions rd_side_chk (
    .clk      (rd_clk),
    .srst     (rd_srst),
    .req      (rd_port.rd),
    .blocked  (rd_port.empty),
    .err_flag (rd_port.uflow)
);

/* tb/cmd_xfer_tb.sv */
`timescale 1ns/100ps

module cmd_xfer_tb;
    import cmd_xfer_pkg::*;

    localparam int DEPTH = 16;
    localparam int CNT_W = fifo_cnt_w(DEPTH, 1'b1);

    typedef enum {READY_RANDOM, READY_LOW, READY_HIGH} ready_mode_t;

    logic             wr_clk, wr_srst, rd_clk, rd_srst;
    logic             cmd_valid, cmd_ready, res_valid, res_ready;
    cmd_op_t          cmd_op;
    logic [ARG_W-1:0] cmd_arg;
    logic [15:0]      cmd_count;
    logic [ACC_W-1:0] res_data;
    logic [CNT_W-1:0] fifo_level;

    // Scoreboard and model state
    cmd_t             cmd_q[$];
    logic [15:0]      hs_count = '0;
    logic [ACC_W-1:0] model_acc = '0;
    logic [ACC_W-1:0] held_data = '0;
    logic             held_valid = 1'b0;
    int               outs_accepted = 0;
    int               results_seen = 0;
    logic [31:0]      wr_rng = 32'd67;
    logic [31:0]      rd_rng = 32'd67;
    ready_mode_t      ready_mode = READY_RANDOM;
    int               ready_run = 0;
    logic             ready_val = 1'b1;

    tb_clkgen #(.PERIOD_NS(10.0)) rd_clkgen_inst (.clk(rd_clk), .srst(rd_srst));
    tb_clkgen #(.PERIOD_NS(14.0)) wr_clkgen_inst (.clk(wr_clk), .srst(wr_srst));

    cmd_xfer_top #(.DEPTH(DEPTH)) cmd_xfer_top_inst (
        .wr_clk     (wr_clk),
        .wr_srst    (wr_srst),
        .rd_clk     (rd_clk),
        .rd_srst    (rd_srst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_arg    (cmd_arg),
        .cmd_ready  (cmd_ready),
        .cmd_count  (cmd_count),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_ready  (res_ready),
        .fifo_level (fifo_level)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state ^ (state << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int bound_failures();
        return cmd_xfer_top_inst.fifo_async_inst.wr_side_chk.fail_count +
               cmd_xfer_top_inst.cmd_consumer_inst.rd_side_chk.fail_count;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // Model runs queued commands up to the next OUT
    task automatic check_result();
        cmd_t c;
        logic found;
        found = 1'b0;
        while (!found && cmd_q.size() > 0) begin
            c = cmd_q.pop_front();
            case (c.op)
                OP_ADD:  model_acc = model_acc + ACC_W'(c.arg);
                OP_SUB:  model_acc = model_acc - ACC_W'(c.arg);
                OP_LOAD: model_acc = ACC_W'(c.arg);
                default: found = 1'b1;
            endcase
        end
        assert (found) else stop_on_error("A result appeared without a matching OUT command");
        assert (res_data == model_acc) else stop_on_error($sformatf(
            "Error: res_data = 0x%04h, expected 0x%04h", res_data, model_acc));
        results_seen++;
    endtask

    task automatic drive_command(input cmd_op_t op, input logic [ARG_W-1:0] arg);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_arg   <= arg;
    endtask

    // About one OUT in five, the rest spread over ADD, SUB and LOAD
    task automatic drive_random_command(input bit allow_gap);
        wr_rng = xorshift32(wr_rng);
        if (allow_gap && wr_rng[31:30] == 2'b00) begin
            cmd_valid <= 1'b0;
            repeat (1 + wr_rng[29:28]) @(posedge wr_clk);
        end
        drive_command((wr_rng[7:0] % 5 == 0) ? OP_OUT : cmd_op_t'(wr_rng[9:8] % 3),
                      wr_rng[23:10]);
    endtask

    // Called after a rising edge with cmd_valid high
    task automatic wait_accept(input int max_wait, output bit accepted);
        int waited;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < max_wait) begin
            @(negedge wr_clk);
            accepted = cmd_ready;
            waited++;
        end
        if (accepted) begin
            @(posedge wr_clk);
        end
    endtask

    task automatic send_random_commands(input int count);
        bit accepted;
        for (int i = 0; i < count; i++) begin
            drive_random_command(1'b1);
            wait_accept(2000, accepted);
            assert (accepted) else stop_on_error("Timed out waiting for cmd_ready");
        end
    endtask

    // ------------------------------------------------------------------
    // Monitors, sampled on falling edges
    // ------------------------------------------------------------------
    always @(negedge wr_clk) begin
        if (!wr_srst) begin
            assert (cmd_count == hs_count) else stop_on_error($sformatf(
                "Error: cmd_count = 0x%04h, expected 0x%04h", cmd_count, hs_count));
            if (cmd_valid && cmd_ready) begin
                cmd_q.push_back('{op: cmd_op, arg: cmd_arg});
                hs_count = hs_count + 16'd1;
                if (cmd_op == OP_OUT) begin
                    outs_accepted++;
                end
            end
        end
    end

    always @(negedge rd_clk) begin
        if (!rd_srst) begin
            assert (bound_failures() == 0) else stop_on_error("A bound FIFO assertion failed");
            assert (fifo_level <= CNT_W'(DEPTH + 1)) else stop_on_error($sformatf(
                "Error: fifo_level = 0x%0h, above 0x%0h", fifo_level, DEPTH + 1));
            // Stalled result must hold
            if (held_valid) begin
                assert (res_valid) else stop_on_error("res_valid dropped before res_ready");
                assert (res_data == held_data) else stop_on_error($sformatf(
                    "Error: res_data = 0x%04h, expected 0x%04h", res_data, held_data));
            end
            held_valid = res_valid && !res_ready;
            held_data  = res_data;
            if (res_valid && res_ready) begin
                check_result();
            end
        end
    end

    // Result back-pressure
    always @(posedge rd_clk) begin
        if (rd_srst || ready_mode == READY_LOW) begin
            res_ready <= 1'b0;
        end else if (ready_mode == READY_HIGH) begin
            res_ready <= 1'b1;
        end else begin
            if (ready_run == 0) begin
                rd_rng    = xorshift32(rd_rng);
                ready_run = 1 + rd_rng[5:0];
                ready_val = (rd_rng[9:8] != 2'b00);
            end
            ready_run = ready_run - 1;
            res_ready <= ready_val;
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin : main_flow
        bit accepted;
        int waited;
        int tries;
        cmd_valid = 1'b0;
        cmd_op    = OP_ADD;
        cmd_arg   = '0;
        res_ready = 1'b0;

        waited = 0;
        @(negedge rd_clk);
        while (rd_srst && waited < 100) begin
            @(negedge rd_clk);
            waited++;
        end
        assert (!rd_srst) else stop_on_error("rd_srst never released");
        assert (res_valid == 1'b0) else stop_on_error($sformatf(
            "Error: res_valid = 0x%0h after reset, expected 0x0", res_valid));
        assert (fifo_level == '0) else stop_on_error($sformatf(
            "Error: fifo_level = 0x%0h after reset, expected 0x0", fifo_level));

        waited = 0;
        @(negedge wr_clk);
        while (wr_srst && waited < 100) begin
            @(negedge wr_clk);
            waited++;
        end
        assert (cmd_ready == 1'b0) else stop_on_error($sformatf(
            "Error: cmd_ready = 0x%0h after reset, expected 0x0", cmd_ready));
        waited = 0;
        while (!cmd_ready && waited < 20) begin
            @(negedge wr_clk);
            waited++;
        end
        assert (cmd_ready) else stop_on_error("cmd_ready did not rise after reset");
        @(posedge wr_clk);

        send_random_commands(300);

        // Results held off until the FIFO and the holding register fill
        @(negedge wr_clk);
        ready_mode = READY_LOW;
        @(posedge wr_clk);
        accepted = 1'b1;
        tries    = 0;
        while (accepted && tries < 200) begin
            drive_random_command(1'b0);
            wait_accept(12, accepted);
            tries++;
        end
        assert (!accepted) else stop_on_error("cmd_ready never fell with res_ready low");
        waited = 0;
        @(negedge rd_clk);
        while (fifo_level != CNT_W'(DEPTH + 1) && waited < 50) begin
            @(negedge rd_clk);
            waited++;
        end
        assert (fifo_level == CNT_W'(DEPTH + 1)) else stop_on_error($sformatf(
            "Error: fifo_level = 0x%0h, expected 0x%0h", fifo_level, DEPTH + 1));
        @(negedge wr_clk);
        ready_mode = READY_RANDOM;
        wait_accept(2000, accepted);
        assert (accepted) else stop_on_error("Stalled command was not accepted after release");

        send_random_commands(300);
        drive_command(OP_OUT, '0);
        wait_accept(2000, accepted);
        assert (accepted) else stop_on_error("Final command was not accepted");
        cmd_valid <= 1'b0;

        // Drain with res_ready held high
        @(negedge wr_clk);
        ready_mode = READY_HIGH;
        waited     = 0;
        while (!(results_seen == outs_accepted && fifo_level == '0 && !res_valid) &&
               waited < 3000) begin
            @(negedge rd_clk);
            waited++;
        end
        assert (results_seen == outs_accepted && fifo_level == '0)
            else stop_on_error("FIFO did not drain after the stimulus stopped");
        repeat (50) begin
            @(negedge rd_clk);
            assert (!res_valid) else stop_on_error("Extra result after the drain");
        end
        assert (cmd_q.size() == 0) else stop_on_error("Commands left over in the scoreboard");

        if (bound_failures() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1);
        end
    end

endmodule : cmd_xfer_tb

/* sources.f */
verilog/cmd_xfer_pkg.sv
verilog/fifo_port_if.sv
verilog/fifo_core.sv
verilog/fifo_async.sv
verilog/cmd_producer.sv
verilog/cmd_consumer.sv
verilog/cmd_xfer_top.sv
tb/tb_clkgen.sv
tb/cmd_xfer_assertions.sv
tb/cmd_xfer_tb.sv
